/* rtl/ppu_pkg.sv */
// Background-only PPU constants; pattern base is fixed, sprite status bits are not modelled
package ppu_pkg;

	// Visible screen size in pixels
	localparam logic [8:0] SCREEN_ROWS = 9'd240;
	localparam logic [8:0] SCREEN_COLS = 9'd256;

	// One tile span is 8 pixels wide
	localparam logic [3:0] TILE_PIXELS = 4'd8;

	// Idle gap after every row, slows the renderer to the display rate
	localparam logic [15:0] LINE_WAIT_CYCLES = 16'd300;

	// Nametables sit in a 2x2 grid starting at 0x2000
	localparam logic [15:0] NAMETABLE_BASE = 16'h2000;
	localparam logic [15:0] NAMETABLE_STRIDE = 16'h0400;

	// Attribute table follows the 30x32 tile map inside each nametable
	localparam logic [15:0] ATTR_OFFSET = 16'h03C0;

	// Background tiles always come from the upper pattern table
	localparam logic [15:0] BG_PATTERN_BASE = 16'h1000;

	// Background palette, four groups of four colour bytes
	localparam logic [15:0] PALETTE_BASE = 16'h3F00;
	localparam logic [4:0] BG_PALETTE_BYTES = 5'd16;

	// CPU visible status register
	localparam logic [15:0] STATUS_ADDR = 16'h2002;

	// Bit positions in ppu_ctrl2 (mask) and ppu_status
	localparam int MASK_BG_ENABLE = 3;
	localparam int MASK_BG_LEFT = 1;
	localparam int STATUS_VBLANK = 7;

	// Frame sequencer state codes
	localparam logic [2:0] SEQ_IDLE = 3'd0;
	localparam logic [2:0] SEQ_PALETTE = 3'd1;
	localparam logic [2:0] SEQ_TILE_START = 3'd2;
	localparam logic [2:0] SEQ_TILE_WAIT = 3'd3;
	localparam logic [2:0] SEQ_LINE_WAIT = 3'd4;
	localparam logic [2:0] SEQ_VGA_WAIT = 3'd5;

endpackage

/* rtl/ppu_palette_load.sv */
// Loads the 16 background palette bytes; VRAM must answer one cycle after the address edge
`timescale 1ns/1ps

module ppu_palette_load import ppu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	output logic [15:0] vram_addr,
	input logic [7:0] vram_data,
	output logic [BG_PALETTE_BYTES*8-1:0] bg_colors
);

	// Address index runs one step ahead of the capture index
	logic [4:0] addr_idx;
	logic cap_valid;
	logic [3:0] cap_idx;

	// Address is presented straight from the counter
	assign vram_addr = PALETTE_BASE + {11'd0, addr_idx};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			addr_idx <= 5'd0;
			cap_valid <= 1'b0;
			cap_idx <= 4'd0;
		end else if (!busy) begin
			cap_valid <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				addr_idx <= 5'd0;
			end
		end else begin
			// Stop walking once every byte address has gone out
			if (addr_idx < BG_PALETTE_BYTES)
				addr_idx <= addr_idx + 5'd1;
			// Data for this address shows up next cycle
			cap_valid <= (addr_idx < BG_PALETTE_BYTES);
			cap_idx <= addr_idx[3:0];
			// Last byte stored ends the job
			if (cap_valid && ({1'b0, cap_idx} == BG_PALETTE_BYTES - 5'd1))
				busy <= 1'b0;
		end
	end

	// Byte n lands in bits 8n+7..8n
	always_ff @(posedge clk) begin
		if (cap_valid)
			bg_colors[{cap_idx, 3'b000} +: 8] <= vram_data;
	end

endmodule

/* rtl/ppu_tile_render.sv */
// Renders one 8-pixel span; inputs must stay stable while busy, frame buffer never stalls
`timescale 1ns/1ps

module ppu_tile_render import ppu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	input logic [8:0] screen_row,
	input logic signed [8:0] screen_col,
	input logic [15:0] scroll,
	input logic [1:0] nt_select,
	input logic [7:0] mask,
	input logic [BG_PALETTE_BYTES*8-1:0] bg_colors,
	output logic [15:0] vram_addr,
	input logic [7:0] vram_data,
	output logic [8:0] vga_row,
	output logic [8:0] vga_col,
	output logic [7:0] vga_data,
	output logic vga_write_en
);

	// World position of the span
	logic [8:0] world_x;
	logic [9:0] y_sum;
	logic [9:0] world_y;
	logic nt_y;
	logic [7:0] local_y;
	logic [4:0] coarse_x;
	logic [4:0] coarse_y;
	logic [2:0] fine_y;

	// Fetch addresses
	logic [15:0] nt_base;
	logic [15:0] nt_addr;
	logic [15:0] attr_addr;
	logic [15:0] pat_lo_addr;
	logic [15:0] pat_hi_addr;
	logic [2:0] attr_shift;
	logic [7:0] attr_shifted;

	// Job sequencing, steps 0..3 fetch and 4..11 write
	logic [3:0] step;
	logic [3:0] write_idx;
	logic write_phase;

	// Fetched tile data
	logic [7:0] tile_q;
	logic [7:0] plane_lo;
	logic [7:0] plane_hi;
	logic [1:0] attr_q;

	// Pixel output path
	logic [9:0] pix_col;
	logic pix_visible;
	logic [1:0] pix_value;
	logic backdrop;

	// X wraps at 512, span start is always tile aligned
	assign world_x = screen_col + {1'b0, scroll[7:0]} + {nt_select[0], 8'h00};

	// Y wraps at 480, a single subtract is enough
	assign y_sum = {1'b0, screen_row} + {2'b00, scroll[15:8]} +
		(nt_select[1] ? {1'b0, SCREEN_ROWS} : 10'd0);
	assign world_y = (y_sum >= {SCREEN_ROWS, 1'b0}) ? y_sum - {SCREEN_ROWS, 1'b0} : y_sum;
	assign nt_y = (world_y >= {1'b0, SCREEN_ROWS});
	assign local_y = nt_y ? 8'(world_y - {1'b0, SCREEN_ROWS}) : world_y[7:0];

	assign coarse_x = world_x[7:3];
	assign coarse_y = local_y[7:3];
	assign fine_y = local_y[2:0];

	// Nametable index is x + 2y in the 2x2 grid
	assign nt_base = NAMETABLE_BASE + {14'd0, nt_y, world_x[8]} * NAMETABLE_STRIDE;
	assign nt_addr = nt_base + {6'd0, coarse_y, coarse_x};
	assign attr_addr = nt_base + ATTR_OFFSET + {10'd0, coarse_y[4:2], coarse_x[4:2]};

	// Low plane addressed from the tile byte arriving this cycle
	assign pat_lo_addr = BG_PATTERN_BASE + {4'd0, vram_data, 4'd0} + {13'd0, fine_y};
	assign pat_hi_addr = BG_PATTERN_BASE + {4'd0, tile_q, 4'd0} + {12'd0, 1'b1, fine_y};

	// Quadrant select inside the 32x32 attribute area
	assign attr_shift = {coarse_y[1], coarse_x[1], 1'b0};
	assign attr_shifted = vram_data >> attr_shift;

	// Nametable address goes out while idle, so the tile byte is ready at step 0
	always_comb begin
		vram_addr = nt_addr;
		if (busy) begin
			case (step)
				4'd0: vram_addr = pat_lo_addr;
				4'd1: vram_addr = pat_hi_addr;
				4'd2: vram_addr = attr_addr;
				default: vram_addr = nt_addr;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			step <= 4'd0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				step <= 4'd0;
			end
		end else if (step == 4'd3 + TILE_PIXELS) begin
			busy <= 1'b0;
			step <= 4'd0;
		end else begin
			step <= step + 4'd1;
		end
	end

	// Capture one byte per fetch step, then shift the planes per pixel
	always_ff @(posedge clk) begin
		if (busy) begin
			case (step)
				4'd0: tile_q <= vram_data;
				4'd1: plane_lo <= vram_data;
				4'd2: plane_hi <= vram_data;
				4'd3: attr_q <= attr_shifted[1:0];
				default: begin
					plane_lo <= {plane_lo[6:0], 1'b0};
					plane_hi <= {plane_hi[6:0], 1'b0};
				end
			endcase
		end
	end

	assign write_phase = busy && (step >= 4'd4);
	assign write_idx = step - 4'd4;

	// Column may start negative, bit 9 flags that
	assign pix_col = {screen_col[8], screen_col} + {7'd0, write_idx[2:0]};
	assign pix_visible = !pix_col[9] && (pix_col < {1'b0, SCREEN_COLS});
	assign pix_value = {plane_hi[7], plane_lo[7]};

	// Transparent pixel, disabled background or masked left strip show the backdrop
	assign backdrop = (pix_value == 2'b00) || !mask[MASK_BG_ENABLE] ||
		((pix_col < {6'd0, TILE_PIXELS}) && !mask[MASK_BG_LEFT]);

	assign vga_row = screen_row;
	assign vga_col = pix_col[8:0];
	assign vga_data = backdrop ? bg_colors[7:0] : bg_colors[{attr_q, pix_value, 3'b000} +: 8];
	assign vga_write_en = write_phase && pix_visible;

endmodule

/* rtl/ppu_status_latch.sv */
// Only the vertical blank flag is kept; sprite hit and overflow bits always read zero
`timescale 1ns/1ps

module ppu_status_latch import ppu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic frame_done,
	input logic frame_start,
	input logic [15:0] cpu_addr,
	input logic cpu_read,
	output logic [7:0] ppu_status
);

	logic vblank;
	logic status_read;

	// CPU is reading the status register this cycle
	assign status_read = cpu_read && (cpu_addr == STATUS_ADDR);

	// Set at the end of the last row
	// Cleared by a status read or a new frame
	// Setting wins so a read in the same cycle does not lose the flag
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vblank <= 1'b0;
		end else if (frame_done) begin
			vblank <= 1'b1;
		end else if (frame_start || status_read) begin
			vblank <= 1'b0;
		end
	end

	// Read value is live, the clear lands on the following edge
	always_comb begin
		ppu_status = 8'h00;
		ppu_status[STATUS_VBLANK] = vblank;
	end

endmodule

/* rtl/ppu_fsm.sv */
// Background-only frame renderer; a new frame needs vga_done low then high, VRAM has 1-cycle reads
`timescale 1ns/1ps

module ppu_fsm import ppu_pkg::*; (
	input logic clk,
	input logic rst,
	output logic [15:0] vram_addr,
	input logic [7:0] vram_data,
	input logic [15:0] cpu_addr,
	input logic cpu_read,
	input logic [7:0] ppu_ctrl1,
	input logic [7:0] ppu_ctrl2,
	output logic [7:0] ppu_status,
	input logic [15:0] cpu_scroll_addr,
	input logic vga_done,
	output logic [8:0] vga_row,
	output logic [8:0] vga_col,
	output logic [7:0] vga_data,
	output logic vga_write_en
);

	// Sequencer state and position
	logic [2:0] state;
	logic [8:0] screen_row;
	logic signed [8:0] screen_col;
	logic [15:0] cnt;

	// Scroll, select and mask latches
	logic [7:0] x_scroll;
	logic [7:0] y_scroll;
	logic [1:0] nt_sel;
	logic [7:0] mask_q;

	// Sub-machine handshakes
	logic palette_start;
	logic palette_busy;
	logic tile_start;
	logic tile_busy;
	logic [15:0] palette_vram_addr;
	logic [15:0] tile_vram_addr;
	logic [BG_PALETTE_BYTES*8-1:0] bg_colors;

	// Sequencer decode
	logic frame_start;
	logic frame_done;
	logic row_start;
	logic tile_done;
	logic span_last;
	logic row_last;
	logic [9:0] col_next;
	logic [8:0] first_col;

	// Frame begins as soon as the display releases the buffer
	assign frame_start = (state == SEQ_IDLE) && vga_done;

	// Row starts after the palette load or after the idle gap
	assign row_start = ((state == SEQ_PALETTE) && !palette_start && !palette_busy) ||
		((state == SEQ_LINE_WAIT) && (cnt == LINE_WAIT_CYCLES - 16'd1));

	// Busy has fallen after the start was taken
	assign tile_done = (state == SEQ_TILE_WAIT) && !tile_start && !tile_busy;

	// Next span start, sign kept in bit 9
	assign col_next = {screen_col[8], screen_col} + {6'd0, TILE_PIXELS};
	assign span_last = !col_next[9] && (col_next >= {1'b0, SCREEN_COLS});
	assign row_last = (screen_row == SCREEN_ROWS - 9'd1);
	assign frame_done = tile_done && span_last && row_last;

	// Row begins at minus the fine X scroll of the value being latched
	assign first_col = 9'd0 - {6'd0, cpu_scroll_addr[2:0]};

	// Y scroll, Y select and mask hold for the whole frame
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			y_scroll <= 8'h00;
			nt_sel[1] <= 1'b0;
			mask_q <= 8'h00;
		end else if (frame_start) begin
			y_scroll <= cpu_scroll_addr[15:8];
			nt_sel[1] <= ppu_ctrl1[1];
			mask_q <= ppu_ctrl2;
		end
	end

	// X scroll and X select are picked up again on every row
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			x_scroll <= 8'h00;
			nt_sel[0] <= 1'b0;
		end else if (row_start) begin
			x_scroll <= cpu_scroll_addr[7:0];
			nt_sel[0] <= ppu_ctrl1[0];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= SEQ_IDLE;
			screen_row <= 9'd0;
			screen_col <= 9'sd0;
			cnt <= 16'd0;
			palette_start <= 1'b0;
			tile_start <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (vga_done) begin
						palette_start <= 1'b1;
						screen_row <= 9'd0;
						state <= SEQ_PALETTE;
					end
				end
				SEQ_PALETTE: begin
					// Drop start once the loader has taken it
					if (palette_start && palette_busy)
						palette_start <= 1'b0;
					if (row_start) begin
						screen_col <= first_col;
						state <= SEQ_TILE_START;
					end
				end
				SEQ_TILE_START: begin
					tile_start <= 1'b1;
					state <= SEQ_TILE_WAIT;
				end
				SEQ_TILE_WAIT: begin
					if (tile_start && tile_busy) begin
						tile_start <= 1'b0;
					end else if (tile_done) begin
						if (!span_last) begin
							screen_col <= col_next[8:0];
							state <= SEQ_TILE_START;
						end else if (row_last) begin
							// Last span of row 239, vblank goes up now
							state <= SEQ_VGA_WAIT;
						end else begin
							screen_row <= screen_row + 9'd1;
							cnt <= 16'd0;
							state <= SEQ_LINE_WAIT;
						end
					end
				end
				SEQ_LINE_WAIT: begin
					if (row_start) begin
						screen_col <= first_col;
						state <= SEQ_TILE_START;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				SEQ_VGA_WAIT: begin
					// Display must take the buffer before the next frame
					if (!vga_done)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	ppu_palette_load u_palette_load (
		.clk(clk),
		.rst(rst),
		.start(palette_start),
		.busy(palette_busy),
		.vram_addr(palette_vram_addr),
		.vram_data(vram_data),
		.bg_colors(bg_colors)
	);

	ppu_tile_render u_tile_render (
		.clk(clk),
		.rst(rst),
		.start(tile_start),
		.busy(tile_busy),
		.screen_row(screen_row),
		.screen_col(screen_col),
		.scroll({y_scroll, x_scroll}),
		.nt_select(nt_sel),
		.mask(mask_q),
		.bg_colors(bg_colors),
		.vram_addr(tile_vram_addr),
		.vram_data(vram_data),
		.vga_row(vga_row),
		.vga_col(vga_col),
		.vga_data(vga_data),
		.vga_write_en(vga_write_en)
	);

	ppu_status_latch u_status_latch (
		.clk(clk),
		.rst(rst),
		.frame_done(frame_done),
		.frame_start(frame_start),
		.cpu_addr(cpu_addr),
		.cpu_read(cpu_read),
		.ppu_status(ppu_status)
	);

	// Palette loader owns VRAM only while it is busy
	assign vram_addr = palette_busy ? palette_vram_addr : tile_vram_addr;

endmodule

/* tb/ppu_assert.sv */
// Port-level checks bound into ppu_fsm; only background writes and the vblank bit are covered
`timescale 1ns/1ps

module ppu_assert import ppu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] ppu_status,
	input logic vga_done,
	input logic [8:0] vga_row,
	input logic [8:0] vga_col,
	input logic vga_write_en
);

	// Running count of property failures
	int fail_count;

	// Writes stay inside the visible screen
	write_in_screen: assert property (@(posedge clk) disable iff (!rst)
		vga_write_en |-> (vga_col < SCREEN_COLS) && (vga_row < SCREEN_ROWS))
		else begin
			fail_count++;
			$error("frame buffer write outside the visible screen");
		end

	// Nothing is drawn during vertical blank
	no_write_in_vblank: assert property (@(posedge clk) disable iff (!rst)
		!(vga_write_en && ppu_status[STATUS_VBLANK]))
		else begin
			fail_count++;
			$error("frame buffer write while vblank is set");
		end

	write_off_in_reset: assert property (@(posedge clk) !rst |-> !vga_write_en)
		else begin
			fail_count++;
			$error("frame buffer write during reset");
		end

	// A frame only finishes while the display holds the buffer free
	vblank_needs_vga_done: assert property (@(posedge clk) disable iff (!rst)
		$rose(ppu_status[STATUS_VBLANK]) |-> vga_done)
		else begin
			fail_count++;
			$error("vblank rose while vga_done was low");
		end

endmodule

bind ppu_fsm ppu_assert u_ppu_assert (
	.clk(clk),
	.rst(rst),
	.ppu_status(ppu_status),
	.vga_done(vga_done),
	.vga_row(vga_row),
	.vga_col(vga_col),
	.vga_write_en(vga_write_en)
);

/* tb/ppu_tb.sv */
// Runs four frames against a random-filled VRAM model; scroll and ctrl inputs are held steady per frame
`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

	// Four frames of roughly 240k cycles each, plus one frame of margin
	localparam int FRAME_CYCLES = 240_000;
	localparam int FRAME_COUNT = 5;
	localparam int TIMEOUT_CYCLES = FRAME_CYCLES * FRAME_COUNT;
	localparam int DRIVE_DELAY = 10;

	logic clk;
	logic rst;
	logic [15:0] vram_addr;
	logic [7:0] vram_data;
	logic [15:0] cpu_addr;
	logic cpu_read;
	logic [7:0] ppu_ctrl1;
	logic [7:0] ppu_ctrl2;
	logic [7:0] ppu_status;
	logic [15:0] cpu_scroll_addr;
	logic vga_done;
	logic [8:0] vga_row;
	logic [8:0] vga_col;
	logic [7:0] vga_data;
	logic vga_write_en;

	// VRAM model and one hit bit per screen pixel
	logic [7:0] vram [0:65535];
	logic hit [0:61439];

	// Settings of the frame in flight, used by the checker
	string test_name;
	logic [15:0] cur_scroll;
	logic [7:0] cur_ctrl1;
	logic [7:0] cur_ctrl2;

	int error_count;
	int check_count;
	int pixel_count;
	int cycle_count;

	ppu_fsm dut_i (
		.clk(clk),
		.rst(rst),
		.vram_addr(vram_addr),
		.vram_data(vram_data),
		.cpu_addr(cpu_addr),
		.cpu_read(cpu_read),
		.ppu_ctrl1(ppu_ctrl1),
		.ppu_ctrl2(ppu_ctrl2),
		.ppu_status(ppu_status),
		.cpu_scroll_addr(cpu_scroll_addr),
		.vga_done(vga_done),
		.vga_row(vga_row),
		.vga_col(vga_col),
		.vga_data(vga_data),
		.vga_write_en(vga_write_en)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// One-cycle synchronous read, data lands just after the edge
	always @(posedge clk)
		vram_data <= #DRIVE_DELAY vram[vram_addr];

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Background pixel from the scroll, select and mask rules
	function automatic logic [7:0] expected_pixel(input int row, input int col,
			input logic [15:0] scroll, input logic [1:0] sel, input logic [7:0] mask);
		int wx;
		int wy;
		int ly;
		int cx;
		int cy;
		int fx;
		int nt_addr;
		int pat_addr;
		int shift;
		int pix;
		logic [7:0] tile;
		logic [7:0] attr;
		// World position over the 2x2 nametable grid
		wx = (col + int'(scroll[7:0]) + 256 * int'(sel[0])) % 512;
		wy = (row + int'(scroll[15:8]) + 240 * int'(sel[1])) % 480;
		ly = wy % 240;
		cx = (wx % 256) / 8;
		cy = ly / 8;
		fx = wx % 8;
		// Nametable index is x + 2y
		nt_addr = int'(NAMETABLE_BASE) + (wx / 256 + 2 * (wy / 240)) * int'(NAMETABLE_STRIDE);
		tile = vram[nt_addr + cy * 32 + cx];
		pat_addr = int'(BG_PATTERN_BASE) + int'(tile) * 16 + ly % 8;
		pix = 2 * int'(vram[pat_addr + 8][7 - fx]) + int'(vram[pat_addr][7 - fx]);
		// Quadrant of the 32x32 attribute block
		attr = vram[nt_addr + int'(ATTR_OFFSET) + (cy / 4) * 8 + cx / 4];
		shift = 4 * ((cy / 2) % 2) + 2 * ((cx / 2) % 2);
		attr = attr >> shift;
		if (pix == 0 || !mask[MASK_BG_ENABLE] || (col < 8 && !mask[MASK_BG_LEFT]))
			return vram[PALETTE_BASE];
		return vram[int'(PALETTE_BASE) + 4 * int'(attr[1:0]) + pix];
	endfunction

	task automatic log_mismatch(input string what, input int expected, input int actual);
		error_count++;
		$display("[ERROR] %s %s: expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
	endtask

	task automatic count_failure(input string msg);
		error_count++;
		$display("%s: %s", test_name, msg);
	endtask

	// Compare every written pixel against the model at mid cycle
	always @(negedge clk) begin : pixel_check
		int idx;
		logic [7:0] exp_data;
		if (rst && vga_write_en) begin
			pixel_count++;
			check_count++;
			if (vga_row >= SCREEN_ROWS || vga_col >= SCREEN_COLS) begin
				count_failure($sformatf("pixel written outside the screen at row %0d col %0d",
					vga_row, vga_col));
			end else begin
				idx = int'(vga_row) * 256 + int'(vga_col);
				if (hit[idx])
					count_failure($sformatf("pixel row %0d col %0d written twice", vga_row, vga_col));
				hit[idx] = 1'b1;
				exp_data = expected_pixel(vga_row, vga_col, cur_scroll, cur_ctrl1[1:0], cur_ctrl2);
				if (vga_data !== exp_data)
					log_mismatch($sformatf("pixel row %0d col %0d", vga_row, vga_col),
						exp_data, vga_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, frame never finished", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Release the buffer, set up the frame, wait for vblank, then audit coverage
	task automatic run_frame(input string name, input logic [15:0] scroll,
			input logic [7:0] ctrl1, input logic [7:0] ctrl2);
		int missing;
		@(posedge clk);
		#DRIVE_DELAY;
		vga_done = 1'b0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		test_name = name;
		cur_scroll = scroll;
		cur_ctrl1 = ctrl1;
		cur_ctrl2 = ctrl2;
		for (int i = 0; i < 61440; i++)
			hit[i] = 1'b0;
		cpu_scroll_addr = scroll;
		ppu_ctrl1 = ctrl1;
		ppu_ctrl2 = ctrl2;
		vga_done = 1'b1;
		// Old flag drops at frame start, new one marks the end
		do @(negedge clk); while (ppu_status[STATUS_VBLANK] !== 1'b0);
		do @(negedge clk); while (ppu_status[STATUS_VBLANK] !== 1'b1);
		check_count++;
		if (ppu_status !== 8'h80)
			log_mismatch("status after frame", 8'h80, ppu_status);
		missing = 0;
		for (int i = 0; i < 61440; i++)
			if (!hit[i])
				missing++;
		check_count++;
		if (missing != 0)
			count_failure($sformatf("%0d pixels were never written in this frame", missing));
	endtask

	// Flag reads as set once, clears on the edge after the read
	task automatic check_status_read();
		@(posedge clk);
		#DRIVE_DELAY;
		test_name = "status";
		cpu_addr = STATUS_ADDR;
		cpu_read = 1'b1;
		@(negedge clk);
		check_count++;
		if (ppu_status !== 8'h80)
			log_mismatch("first status read", 8'h80, ppu_status);
		@(negedge clk);
		check_count++;
		if (ppu_status !== 8'h00)
			log_mismatch("second status read", 8'h00, ppu_status);
		@(posedge clk);
		#DRIVE_DELAY;
		cpu_read = 1'b0;
		cpu_addr = 16'h0000;
	endtask

	initial begin : stimulus
		logic [31:0] seed;
		rst = 1'b0;
		vram_data = 8'h00;
		cpu_addr = 16'h0000;
		cpu_read = 1'b0;
		ppu_ctrl1 = 8'h00;
		ppu_ctrl2 = 8'h00;
		cpu_scroll_addr = 16'h0000;
		vga_done = 1'b0;
		test_name = "reset";
		cur_scroll = 16'h0000;
		cur_ctrl1 = 8'h00;
		cur_ctrl2 = 8'h00;
		error_count = 0;
		check_count = 0;
		pixel_count = 0;
		cycle_count = 0;
		seed = 32'h6bed4291;
		for (int a = 0; a < 65536; a++) begin
			seed = next_random(seed);
			vram[a] = seed[7:0];
		end
		// Status and write enable stay quiet through reset and just after
		repeat (16) begin
			@(negedge clk);
			check_count++;
			if (ppu_status !== 8'h00)
				log_mismatch("status in reset", 8'h00, ppu_status);
			if (vga_write_en !== 1'b0)
				log_mismatch("write enable in reset", 0, vga_write_en);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_count++;
			if (ppu_status !== 8'h00 || vga_write_en !== 1'b0)
				count_failure("status or write enable active right after reset");
		end
		// BG on with left strip shown
		run_frame("plain", 16'h0000, 8'h00, 8'h0A);
		// Negative start column, nametable crossing, left strip masked
		run_frame("hscroll", 16'h002D, 8'h01, 8'h08);
		// Rows wrap across the 240-row boundary
		run_frame("vwrap", 16'hC800, 8'h02, 8'h0A);
		check_status_read();
		// New palette, background off, so every pixel is the new backdrop
		for (int i = 0; i < 16; i++)
			vram[int'(PALETTE_BASE) + i] = ~vram[int'(PALETTE_BASE) + i];
		run_frame("palette", 16'h0000, 8'h00, 8'h02);
		$display("Checks %0d, pixels %0d, errors %0d, assertion failures %0d", check_count,
			pixel_count, error_count, dut_i.u_ppu_assert.fail_count);
		if (error_count == 0 && dut_i.u_ppu_assert.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* list.f */
rtl/ppu_pkg.sv
rtl/ppu_palette_load.sv
rtl/ppu_tile_render.sv
rtl/ppu_status_latch.sv
rtl/ppu_fsm.sv
tb/ppu_assert.sv
tb/ppu_tb.sv

/* Bender.yml */
package:
  name: ppu_render

sources:
  - files:
      - rtl/ppu_pkg.sv
      - rtl/ppu_palette_load.sv
      - rtl/ppu_tile_render.sv
      - rtl/ppu_status_latch.sv
      - rtl/ppu_fsm.sv
  - target: test
    files:
      - tb/ppu_assert.sv
      - tb/ppu_tb.sv
